/* filelist.f */
logic/epd_pixel_pkg.sv
logic/epd_ctrl_pkg.sv
logic/pixel_input_stage.sv
logic/waveform_stage.sv
logic/pixel_pipeline.sv
testbench/tb_pixel_pipeline.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the pixel pipeline testbench with Verilator and runs it.
# The exit status is the simulation result.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f filelist.f --top-module tb_pixel_pipeline \
    --Mdir obj_dir -o tb_pixel_pipeline
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit $build_status
fi

./obj_dir/tb_pixel_pipeline
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "Simulation failed with status $sim_status"
    exit $sim_status
fi

echo "Simulation passed"
exit 0

/* testbench/tb_pixel_pipeline.sv */
// Testbench for the e-paper pixel waveform pipeline
// Directed tests per mode and command, then a random stream under back-pressure,
// each output checked against a rule model of the pixel update
module tb_pixel_pipeline;
    timeunit 1ns;
    timeprecision 1ps;
    import epd_pixel_pkg::*;
    import epd_ctrl_pkg::*;

    localparam frame_cnt_t LUTFRAME = 6'd12;
    localparam mindrv_t    MINDRV   = 2'd2;
    localparam logic [7:0] NO_OP    = 8'h00;
    // 16 directed items at about four cycles each and 200 random items at
    // half rate out_ready come to some 500 cycles
    localparam int MAX_CYCLES = 2000;

    logic       clk;
    logic       rst;
    frame_cnt_t csr_lutframe;
    mindrv_t    csr_mindrv;
    logic       in_valid;
    logic       in_ready;
    pixel_in_t  in_data;
    logic       out_valid;
    logic       out_ready;
    pixel_out_t out_data;

    integer     seed;
    int         cycles = 0;
    int         stall_cnt = 0;
    logic       head_seen = 1'b0;
    pixel_out_t last_out;
    // Expected results with their acceptance cycle and stall mark
    pixel_out_t exp_q[$];
    int         acc_q[$];
    int         mark_q[$];

    pixel_pipeline i_dut (
        .clk          (clk),
        .rst          (rst),
        .csr_lutframe (csr_lutframe),
        .csr_mindrv   (csr_mindrv),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_data      (in_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_data     (out_data)
    );

    always #10 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            fail_run("Timeout: the pipeline did not finish within the cycle limit");
        end
    end

    // Fast mono word with bit 1 unused and zero
    function automatic pixel_state_t fm_word(input logic [3:0] mode, input frame_cnt_t cnt,
                                             input mindrv_t cap, input logic prev);
        return {mode, 2'b00, cnt, cap, 1'b0, prev};
    endfunction

    function automatic pixel_state_t lut_word(input grey_t src, input frame_cnt_t cnt,
                                              input grey_t tgt);
        return {2'b00, src, cnt, tgt};
    endfunction

    function automatic pixel_in_t make_in(input pixel_state_t st, input grey_t orig,
                                          input logic bayer, input logic bn1,
                                          input drive_t lut_rd, input logic [7:0] cmd,
                                          input logic [7:0] param, input logic [7:0] fcnt);
        pixel_in_t d;
        d.state = st;
        d.p_orig = orig;
        d.p_bayer = bayer;
        d.p_bn1 = bn1;
        d.lut_rd = lut_rd;
        d.ctrl.op_valid = (cmd != NO_OP);
        d.ctrl.op_cmd = cmd;
        d.ctrl.op_param = param;
        d.ctrl.op_framecnt = fcnt;
        return d;
    endfunction

    // Rule model of one pixel update
    function automatic pixel_out_t ref_model(input pixel_in_t d);
        pixel_out_t r;
        frame_ctrl_t c;
        logic       clear;
        logic       setm;
        logic       vw;
        grey_t      v;
        frame_cnt_t cnt;
        mindrv_t    cap;
        c = d.ctrl;
        cnt = d.state[9:4];
        cap = d.state[3:2];
        clear = c.op_valid && ((c.op_cmd == OP_EXT_REDRAW)
                || ((c.op_cmd == OP_EXT_SETMODE) && (c.op_framecnt != 8'd0)));
        setm = c.op_valid && (c.op_cmd == OP_EXT_SETMODE) && (c.op_framecnt == 8'd0);
        r.state = d.state;
        r.drive = DRIVE_NONE;
        if (d.state[15:14] == 2'b00) begin
            if (cnt != 6'd0) begin
                r.drive = d.lut_rd;
                r.state[9:4] = cnt - 6'd1;
            end else if (clear) begin
                r.state[13:0] = {d.state[3:0], csr_lutframe, 4'hF};
            end
        end else begin
            // Clear colour alternates black and white with the frame count
            if (clear) v = (c.op_framecnt[3] || (c.op_framecnt[2:1] == 2'b11)) ? 4'h0 : 4'hF;
            else if (d.state[15:12] == MODE_FAST_MONO_BD) v = {4{d.p_bayer}};
            else if (d.state[15:12] == MODE_FAST_MONO_BN) v = {4{d.p_bn1}};
            else v = d.p_orig;
            vw = v[3];
            if ((vw != d.state[0]) && ((cnt == 6'd0) || (cap == 2'd0))) begin
                r.drive = vw ? DRIVE_WHITE : DRIVE_BLACK;
                if (cnt == 6'd0) r.state[9:4] = vw ? FASTM_B2W_FRAMES : FASTM_W2B_FRAMES;
                else r.state[9:4] = 6'd10 - cnt;
                r.state[3:0] = {csr_mindrv, 1'b0, vw};
            end else if (cnt != 6'd0) begin
                r.drive = d.state[0] ? DRIVE_WHITE : DRIVE_BLACK;
                r.state[9:4] = cnt - 6'd1;
                r.state[3:2] = (cap == 2'd0) ? 2'd0 : cap - 2'd1;
            end
        end
        if (setm) begin
            case (c.op_param)
                8'd1:    r.state = {MODE_FAST_MONO_ND, 12'h001};
                8'd2:    r.state = {MODE_FAST_MONO_BD, 12'h001};
                8'd3:    r.state = {MODE_FAST_MONO_BN, 12'h001};
                default: r.state = 16'h000F;
            endcase
        end
        return r;
    endfunction

    task automatic check_out(input pixel_out_t got, input pixel_out_t exp, input string where);
        assert (got.state == exp.state) else fail_run($sformatf(
            "ERROR out_data.state got 0x%h expected 0x%h (%s)", got.state, exp.state, where));
        assert (got.drive == exp.drive) else fail_run($sformatf(
            "ERROR out_data.drive got 0x%h expected 0x%h (%s)", got.drive, exp.drive, where));
    endtask

    // Scoreboard sampled mid-cycle, where every handshake signal is settled
    always @(negedge clk) begin
        if (!rst) begin
            if (out_valid && !head_seen) begin
                head_seen = 1'b1;
                assert (exp_q.size() != 0) else fail_run("An output appeared with no item sent");
                // Unstalled item shows up two cycles after it was presented
                if (mark_q[0] == stall_cnt) begin
                    assert (cycles - acc_q[0] == 2) else fail_run($sformatf(
                        "Latency was %0d cycles instead of 2", cycles - acc_q[0]));
                end
            end
            if (out_valid && out_ready) begin
                check_out(out_data, exp_q[0], "scoreboard");
                last_out = out_data;
                void'(exp_q.pop_front());
                void'(acc_q.pop_front());
                void'(mark_q.pop_front());
                head_seen = 1'b0;
            end
            if (out_valid && !out_ready) stall_cnt++;
            if (in_valid && in_ready) begin
                exp_q.push_back(ref_model(in_data));
                acc_q.push_back(cycles);
                mark_q.push_back(stall_cnt);
            end
        end
    end

    // Called 2 ns after a rising edge, returns 2 ns after the accepting edge
    task automatic send_item(input pixel_in_t d);
        logic taken;
        in_data = d;
        in_valid = 1'b1;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = in_ready;
            @(posedge clk);
        end
        #2;
        in_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(posedge clk);
        #2;
    endtask

    task automatic run_item(input pixel_in_t d, input pixel_out_t exp);
        send_item(d);
        drain();
        check_out(last_out, exp, "directed");
    endtask

    task automatic test_fast_mono_start();
        pixel_state_t w;
        w = fm_word(MODE_FAST_MONO_ND, 6'd0, 2'd0, 1'b1);
        run_item(make_in(w, 4'h0, 1'b0, 1'b0, DRIVE_NONE, NO_OP, 8'h00, 8'h00),
                 {fm_word(MODE_FAST_MONO_ND, 6'd9, MINDRV, 1'b0), DRIVE_BLACK});
        run_item(make_in(w, 4'hF, 1'b0, 1'b0, DRIVE_NONE, NO_OP, 8'h00, 8'h00), {w, DRIVE_NONE});
    endtask

    task automatic test_rate_cap();
        // Change refused while the cap runs
        run_item(make_in(fm_word(MODE_FAST_MONO_ND, 6'd5, 2'd2, 1'b1), 4'h0, 1'b0, 1'b0,
                         DRIVE_NONE, NO_OP, 8'h00, 8'h00),
                 {fm_word(MODE_FAST_MONO_ND, 6'd4, 2'd1, 1'b1), DRIVE_WHITE});
        // Expired cap lets the pixel turn with 10 - 3 frames
        run_item(make_in(fm_word(MODE_FAST_MONO_ND, 6'd3, 2'd0, 1'b1), 4'h0, 1'b0, 1'b0,
                         DRIVE_NONE, NO_OP, 8'h00, 8'h00),
                 {fm_word(MODE_FAST_MONO_ND, 6'd7, MINDRV, 1'b0), DRIVE_BLACK});
        run_item(make_in(fm_word(MODE_FAST_MONO_BD, 6'd0, 2'd0, 1'b0), 4'h0, 1'b1, 1'b0,
                         DRIVE_NONE, NO_OP, 8'h00, 8'h00),
                 {fm_word(MODE_FAST_MONO_BD, 6'd9, MINDRV, 1'b1), DRIVE_WHITE});
        run_item(make_in(fm_word(MODE_FAST_MONO_BN, 6'd0, 2'd0, 1'b1), 4'hF, 1'b1, 1'b0,
                         DRIVE_NONE, NO_OP, 8'h00, 8'h00),
                 {fm_word(MODE_FAST_MONO_BN, 6'd9, MINDRV, 1'b0), DRIVE_BLACK});
    endtask

    task automatic test_manual_lut();
        run_item(make_in(lut_word(4'h3, 6'd7, 4'hA), 4'h0, 1'b0, 1'b0, DRIVE_WHITE,
                         NO_OP, 8'h00, 8'h00),
                 {lut_word(4'h3, 6'd6, 4'hA), DRIVE_WHITE});
        run_item(make_in(lut_word(4'h3, 6'd0, 4'hA), 4'h0, 1'b0, 1'b0, DRIVE_BLACK,
                         OP_EXT_REDRAW, 8'h00, 8'h00),
                 {lut_word(4'hA, LUTFRAME, 4'hF), DRIVE_NONE});
    endtask

    task automatic test_set_mode();
        pixel_state_t w;
        w = fm_word(MODE_FAST_MONO_ND, 6'd0, 2'd0, 1'b1);
        run_item(make_in(w, 4'hF, 1'b0, 1'b0, DRIVE_NONE, OP_EXT_SETMODE, 8'd0, 8'd0),
                 {16'h000F, DRIVE_NONE});
        run_item(make_in(w, 4'hF, 1'b0, 1'b0, DRIVE_NONE, OP_EXT_SETMODE, 8'd1, 8'd0),
                 {MODE_FAST_MONO_ND, 12'h001, DRIVE_NONE});
        run_item(make_in(w, 4'hF, 1'b0, 1'b0, DRIVE_NONE, OP_EXT_SETMODE, 8'd2, 8'd0),
                 {MODE_FAST_MONO_BD, 12'h001, DRIVE_NONE});
        run_item(make_in(w, 4'hF, 1'b0, 1'b0, DRIVE_NONE, OP_EXT_SETMODE, 8'd3, 8'd0),
                 {MODE_FAST_MONO_BN, 12'h001, DRIVE_NONE});
        run_item(make_in(w, 4'hF, 1'b0, 1'b0, DRIVE_NONE, OP_EXT_SETMODE, 8'd7, 8'd0),
                 {16'h000F, DRIVE_NONE});
        // Frame count 6 clears to black, 2 clears to white
        run_item(make_in(w, 4'hF, 1'b0, 1'b0, DRIVE_NONE, OP_EXT_SETMODE, 8'd1, 8'd6),
                 {fm_word(MODE_FAST_MONO_ND, 6'd9, MINDRV, 1'b0), DRIVE_BLACK});
        run_item(make_in(w, 4'h0, 1'b0, 1'b0, DRIVE_NONE, OP_EXT_SETMODE, 8'd1, 8'd2),
                 {w, DRIVE_NONE});
        run_item(make_in(lut_word(4'h5, 6'd0, 4'h2), 4'h0, 1'b0, 1'b0, DRIVE_NONE,
                         OP_EXT_SETMODE, 8'd1, 8'd3),
                 {lut_word(4'h2, LUTFRAME, 4'hF), DRIVE_NONE});
    endtask

    function automatic pixel_in_t random_item();
        logic [31:0] r1;
        logic [31:0] r2;
        r1 = $random(seed);
        r2 = $random(seed);
        // Drive code 3 never comes from the LUT
        return make_in(r1[15:0], r1[19:16], r1[20], r1[21],
                       (r1[23:22] == 2'd3) ? DRIVE_NONE : r1[23:22],
                       (r2[2:0] != 3'd0) ? NO_OP : (r2[3] ? OP_EXT_REDRAW : OP_EXT_SETMODE),
                       {5'd0, r2[6:4]}, r2[7] ? 8'd0 : r2[15:8]);
    endfunction

    task automatic test_back_pressure(input int n);
        int          sent;
        logic        taken;
        logic [31:0] r;
        sent = 0;
        in_data = random_item();
        in_valid = 1'b1;
        while (sent < n) begin
            @(negedge clk);
            taken = in_ready;
            @(posedge clk);
            #2;
            r = $random(seed);
            out_ready = r[0];
            if (taken) begin
                sent++;
                if (sent < n) in_data = random_item();
                else in_valid = 1'b0;
            end
        end
        out_ready = 1'b1;
        drain();
    endtask

    initial begin
        seed = 32'hb8dd;
        clk = 1'b0;
        rst = 1'b1;
        in_valid = 1'b0;
        in_data = '0;
        out_ready = 1'b1;
        csr_lutframe = LUTFRAME;
        csr_mindrv = MINDRV;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        test_fast_mono_start();
        test_rate_cap();
        test_manual_lut();
        test_set_mode();
        test_back_pressure(200);
        $display("Test OK");
        $finish;
    end

endmodule

/* logic/pixel_pipeline.sv */
// E-paper pixel waveform pipeline
// Two stage pipeline from VRAM state, source pixels and LUT readout
// to the new state word and panel drive code
module pixel_pipeline (
    input  logic                      clk,
    input  logic                      rst,
    input  epd_pixel_pkg::frame_cnt_t csr_lutframe,
    input  epd_pixel_pkg::mindrv_t    csr_mindrv,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  epd_ctrl_pkg::pixel_in_t   in_data,
    output logic                      out_valid,
    input  logic                      out_ready,
    output epd_ctrl_pkg::pixel_out_t  out_data
);
    import epd_ctrl_pkg::*;

    // Decoded item between stages
    logic        s1_valid;
    logic        s1_ready;
    stage_item_t s1_data;

    // Mode and command decode
    pixel_input_stage i_input (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_data  (in_data),
        .s1_valid (s1_valid),
        .s1_ready (s1_ready),
        .s1_data  (s1_data)
    );

    // Next state and drive
    waveform_stage i_waveform (
        .clk          (clk),
        .rst          (rst),
        .csr_lutframe (csr_lutframe),
        .csr_mindrv   (csr_mindrv),
        .s1_valid     (s1_valid),
        .s1_ready     (s1_ready),
        .s1_data      (s1_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_data     (out_data)
    );

endmodule

/* logic/waveform_stage.sv */
// Pixel pipeline waveform stage
// Computes the next VRAM state word and the panel drive code for
// manual LUT and fast mono pixels, then registers the result
module waveform_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  epd_pixel_pkg::frame_cnt_t csr_lutframe,
    input  epd_pixel_pkg::mindrv_t    csr_mindrv,
    input  logic                      s1_valid,
    output logic                      s1_ready,
    input  epd_ctrl_pkg::stage_item_t s1_data,
    output logic                      out_valid,
    input  logic                      out_ready,
    output epd_ctrl_pkg::pixel_out_t  out_data
);
    import epd_pixel_pkg::*;
    import epd_ctrl_pkg::*;

    pixel_state_t st;
    frame_cnt_t   cnt;
    frame_cnt_t   cnt_dec;
    frame_cnt_t   cnt_turn;
    frame_cnt_t   cnt_start;
    mindrv_t      cap;
    mindrv_t      cap_dec;
    logic         prev_white;
    logic         vin_white;
    drive_t       drive_toward;
    drive_t       drive_hold;
    pixel_state_t init_word;
    pixel_state_t next_state;
    drive_t       drive;
    pixel_out_t   result;

    // State word fields
    assign st = s1_data.state;
    assign cnt = st[9:4];
    assign cap = st[3:2];
    assign prev_white = st[0];
    assign vin_white = s1_data.vin[3];

    assign cnt_dec = cnt - 6'd1;
    // Cap counts down to zero and stays there
    assign cap_dec = (cap != 2'd0) ? (cap - 2'd1) : 2'd0;

    // Reversal mid-update only needs the frames already spent
    assign cnt_turn = vin_white ? (FASTM_B2W_FRAMES - cnt + 6'd1)
                                : (FASTM_W2B_FRAMES - cnt + 6'd1);
    assign cnt_start = vin_white ? FASTM_B2W_FRAMES : FASTM_W2B_FRAMES;

    assign drive_toward = vin_white ? DRIVE_WHITE : DRIVE_BLACK;
    assign drive_hold = prev_white ? DRIVE_WHITE : DRIVE_BLACK;

    // Initial word for set-mode
    always_comb begin
        case (s1_data.op_param)
            SETMODE_MANUAL_LUT:   init_word = INIT_MANUAL_LUT;
            SETMODE_FAST_MONO_ND: init_word = INIT_FAST_MONO_ND;
            SETMODE_FAST_MONO_BD: init_word = INIT_FAST_MONO_BD;
            SETMODE_FAST_MONO_BN: init_word = INIT_FAST_MONO_BN;
            // Bad code, back to manual LUT
            default:              init_word = INIT_MANUAL_LUT;
        endcase
    end

    always_comb begin
        next_state = st;
        drive = DRIVE_NONE;
        if (s1_data.base_mode == BASE_MANUAL_LUT) begin
            if (cnt != 6'd0) begin
                // LUT walk in progress, requests ignored
                drive = s1_data.lut_rd;
                next_state = {st[15:10], cnt_dec, st[3:0]};
            end else if (s1_data.force_clear) begin
                // Old target becomes the source
                next_state = {st[15:14], st[3:0], csr_lutframe, s1_data.vin};
            end
        end else begin
            if (cnt != 6'd0) begin
                if ((vin_white != prev_white) && (cap == 2'd0)) begin
                    // Turn around mid-update
                    drive = drive_toward;
                    next_state = {st[15:10], cnt_turn, csr_mindrv, 1'b0, vin_white};
                end else begin
                    // Keep pushing the previous colour
                    drive = drive_hold;
                    next_state = {st[15:10], cnt_dec, cap_dec, st[1:0]};
                end
            end else if (vin_white != prev_white) begin
                // Fresh update from idle
                drive = drive_toward;
                next_state = {st[15:10], cnt_start, csr_mindrv, 1'b0, vin_white};
            end
        end
        // Set-mode wins over the mode rules
        if (s1_data.set_mode_apply) begin
            next_state = init_word;
        end
    end

    assign result.state = next_state;
    assign result.drive = drive;

    // Output register
    assign s1_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (s1_ready) begin
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid && s1_ready) begin
            out_data <= result;
        end
    end

    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
        else $error("out_data changed while stalled");

    // LUT readout passes straight through, so guard the whole path
    a_drive_code: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> (out_data.drive != 2'd3))
        else $error("illegal drive code on out_data");

endmodule

/* logic/pixel_input_stage.sv */
// Pixel pipeline input stage
// Decodes the pixel mode and the frame command, picks the target value
// and registers the decoded item behind a valid/ready handshake
module pixel_input_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  epd_ctrl_pkg::pixel_in_t   in_data,
    output logic                      s1_valid,
    input  logic                      s1_ready,
    output epd_ctrl_pkg::stage_item_t s1_data
);
    import epd_pixel_pkg::*;
    import epd_ctrl_pkg::*;

    logic [3:0]  mode;
    base_mode_e  base_mode;
    dither_e     dither;
    logic        redraw_en;
    logic        set_mode_en;
    logic        force_clear;
    logic        set_mode_apply;
    grey_t       clear_color;
    grey_t       vin;
    stage_item_t item;

    assign mode = in_data.state[15:12];

    // Mode decode
    always_comb begin
        base_mode = BASE_FAST_MONO;
        dither = DITHER_NONE;
        if (mode[3:2] == MODE_MANUAL_LUT) begin
            // Bits 13-12 belong to the source field here
            base_mode = BASE_MANUAL_LUT;
        end else begin
            case (mode)
                MODE_FAST_MONO_ND: dither = DITHER_NONE;
                MODE_FAST_MONO_BD: dither = DITHER_BAYER;
                MODE_FAST_MONO_BN: dither = DITHER_BN1;
                // Unknown code, plain fast mono
                default:           dither = DITHER_NONE;
            endcase
        end
    end

    // Frame command decode
    assign redraw_en = in_data.ctrl.op_valid && (in_data.ctrl.op_cmd == OP_EXT_REDRAW);
    assign set_mode_en = in_data.ctrl.op_valid && (in_data.ctrl.op_cmd == OP_EXT_SETMODE);
    assign force_clear = redraw_en || (set_mode_en && (in_data.ctrl.op_framecnt != 8'd0));
    assign set_mode_apply = set_mode_en && (in_data.ctrl.op_framecnt == 8'd0);

    // Clear colour, fast mono alternates with the frame counter
    always_comb begin
        if (base_mode == BASE_MANUAL_LUT) begin
            clear_color = GREY_WHITE;
        end else if ((in_data.ctrl.op_framecnt[2:1] == 2'b11) || in_data.ctrl.op_framecnt[3]) begin
            clear_color = GREY_BLACK;
        end else begin
            clear_color = GREY_WHITE;
        end
    end

    // Target value
    always_comb begin
        if (force_clear) begin
            vin = clear_color;
        end else begin
            case (dither)
                DITHER_BAYER: vin = {4{in_data.p_bayer}};
                DITHER_BN1:   vin = {4{in_data.p_bn1}};
                default:      vin = in_data.p_orig;
            endcase
        end
    end

    always_comb begin
        item.state = in_data.state;
        item.vin = vin;
        item.lut_rd = in_data.lut_rd;
        item.base_mode = base_mode;
        item.force_clear = force_clear;
        item.set_mode_apply = set_mode_apply;
        item.op_param = in_data.ctrl.op_param;
    end

    // Output register, refills as the next stage drains
    assign in_ready = !s1_valid || s1_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else if (in_ready) begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            s1_data <= item;
        end
    end

    // Stalled item held until the waveform stage takes it
    a_s1_hold: assert property (@(posedge clk) disable iff (rst)
        (s1_valid && !s1_ready) |=> (s1_valid && $stable(s1_data)))
        else $error("s1_data changed while stalled");

endmodule

/* logic/epd_ctrl_pkg.sv */
// E-paper frame control definitions
// External command codes, set-mode parameters and the pipeline item structs
package epd_ctrl_pkg;
    import epd_pixel_pkg::*;

    localparam logic [7:0] OP_EXT_REDRAW  = 8'h01;
    localparam logic [7:0] OP_EXT_SETMODE = 8'h02;

    // Set-mode parameter codes, others fall back to manual LUT
    localparam logic [7:0] SETMODE_MANUAL_LUT   = 8'd0;
    localparam logic [7:0] SETMODE_FAST_MONO_ND = 8'd1;
    localparam logic [7:0] SETMODE_FAST_MONO_BD = 8'd2;
    localparam logic [7:0] SETMODE_FAST_MONO_BN = 8'd3;

    // Frame level command, carried with every pixel
    typedef struct packed {
        logic       op_valid;
        logic [7:0] op_cmd;
        logic [7:0] op_param;
        logic [7:0] op_framecnt;
    } frame_ctrl_t;

    typedef struct packed {
        pixel_state_t state;
        grey_t        p_orig;
        logic         p_bayer;
        logic         p_bn1;
        drive_t       lut_rd;
        frame_ctrl_t  ctrl;
    } pixel_in_t;

    typedef struct packed {
        pixel_state_t state;
        drive_t       drive;
    } pixel_out_t;

    // Decoded item between the two stages
    typedef struct packed {
        pixel_state_t state;
        grey_t        vin;
        drive_t       lut_rd;
        base_mode_e   base_mode;
        logic         force_clear;
        logic         set_mode_apply;
        logic [7:0]   op_param;
    } stage_item_t;

endpackage

/* logic/epd_pixel_pkg.sv */
// E-paper pixel definitions
// VRAM state word layout, pixel mode codes, fast mono frame counts,
// initial state words and panel drive codes
package epd_pixel_pkg;

    // Pixel state word from VRAM
    // 15-12 mode, 13-10 source (manual LUT), 9-4 frame counter
    // 3-2 rate cap (fast mono), 3-0 target (manual LUT)
    // Bit 0 previous colour in fast mono, 1 is white
    typedef logic [15:0] pixel_state_t;
    typedef logic [3:0]  grey_t;
    typedef logic [5:0]  frame_cnt_t;
    typedef logic [1:0]  mindrv_t;
    typedef logic [1:0]  drive_t;

    typedef enum logic {
        BASE_MANUAL_LUT,
        BASE_FAST_MONO
    } base_mode_e;

    typedef enum logic [1:0] {
        DITHER_NONE,
        DITHER_BAYER,
        DITHER_BN1
    } dither_e;

    // Manual LUT only looks at the top two mode bits
    localparam logic [1:0] MODE_MANUAL_LUT   = 2'b00;
    localparam logic [3:0] MODE_FAST_MONO_ND = 4'd8;
    localparam logic [3:0] MODE_FAST_MONO_BD = 4'd9;
    localparam logic [3:0] MODE_FAST_MONO_BN = 4'd10;

    // Full transition lengths in fast mono
    localparam frame_cnt_t FASTM_B2W_FRAMES = 6'd9;
    localparam frame_cnt_t FASTM_W2B_FRAMES = 6'd9;

    localparam grey_t GREY_BLACK = 4'h0;
    localparam grey_t GREY_WHITE = 4'hF;

    // Panel drive codes, 3 is never driven
    localparam drive_t DRIVE_NONE  = 2'd0;
    localparam drive_t DRIVE_BLACK = 2'd1;
    localparam drive_t DRIVE_WHITE = 2'd2;

    // Initial words, counters idle
    localparam pixel_state_t INIT_MANUAL_LUT   = {MODE_MANUAL_LUT, 4'h0, 6'd0, GREY_WHITE};
    localparam pixel_state_t INIT_FAST_MONO_ND = {MODE_FAST_MONO_ND, 2'b00, 6'd0, 4'b0001};
    localparam pixel_state_t INIT_FAST_MONO_BD = {MODE_FAST_MONO_BD, 2'b00, 6'd0, 4'b0001};
    localparam pixel_state_t INIT_FAST_MONO_BN = {MODE_FAST_MONO_BN, 2'b00, 6'd0, 4'b0001};

endpackage
